/* Bender.yml */
package:
  name: feature_evaluator

sources:
  - include_dirs:
      - .
    files:
      - cascadePkg.sv
      - windowPkg.sv
      - cascadeSequencer.sv
      - rectAreaUnit.sv
      - classifierScore.sv
      - stageAccumulator.sv
      - featureEvaluator.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - featureEvaluatorTb.sv

/* cascadePkg.sv */
`include "featureEval_config.svh"

package cascadePkg;

  // signed cascade value, weights, alphas and stage thresholds
  typedef logic signed [`CASCADE_WORD-1:0] fixedT;

  // classifier word, top bit says the feature has a third rectangle
  typedef struct packed {
    logic                           threeRects;
    logic signed [`CASCADE_WORD-2:0] threshold;
  } classifierFieldsT;

  // one cascade word, read either as a plain value or as a classifier header
  typedef union packed {
    fixedT            value;
    classifierFieldsT classifier;
  } classifierWordT;

  typedef enum logic [4:0] {
    stIdle,
    stPrime,
    stNumStages,
    stClassCount,
    stStageThresh,
    stClassWord,
    stWeight1,
    stWeight2,
    stWeight3,
    stAlpha1,
    stAlpha2,
    stRectGo,
    stRectWait,
    stScore,
    stScoreWait,
    stStageEnd,
    stStageWait,
    stDone
  } seqStateT;

endpackage

/* cascadeSequencer.sv */
`include "featureEval_config.svh"

module cascadeSequencer (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          start,
  input  cascadePkg::classifierWordT    cascadeQ,
  input  logic                          rectDone,
  input  logic                          stagePass,
  input  logic                          stageResult,
  input  logic                          alphaValid,
  output logic [`CASCADE_ADDR_BITS-1:0] cascadeAddr,
  output logic                          ready,
  output logic                          done,
  output logic                          passFail,
  output logic                          evalStart,
  output logic                          rectStart,
  output logic                          weightLoad,
  output cascadePkg::fixedT             weight,
  output logic                          classifierEnd,
  output cascadePkg::fixedT             classThreshold,
  output cascadePkg::fixedT             alphaLow,
  output cascadePkg::fixedT             alphaHigh,
  output logic                          stageEnd,
  output cascadePkg::fixedT             stageThreshold
);

  cascadePkg::seqStateT     state;
  cascadePkg::seqStateT     nextState;
  logic [`CASCADE_WORD-1:0] stagesLeft;
  logic [`CASCADE_WORD-1:0] classLeft;
  logic [1:0]               rectIdx;
  logic                     threeRects;
  logic                     lastRect;
  logic                     addrAdvance;
  logic                     passReg;
  cascadePkg::fixedT        weight1;
  cascadePkg::fixedT        weight2;
  cascadePkg::fixedT        weight3;

  assign lastRect = threeRects ? (rectIdx == 2'd2) : (rectIdx == 2'd1);

  // address steps on each edge into a fetch state and holds while scoring
  // so the next header word already sits on cascadeQ when fetching resumes
  assign addrAdvance = nextState inside {cascadePkg::stNumStages, cascadePkg::stClassCount,
                                         cascadePkg::stStageThresh, cascadePkg::stClassWord,
                                         cascadePkg::stWeight1, cascadePkg::stWeight2,
                                         cascadePkg::stWeight3, cascadePkg::stAlpha1,
                                         cascadePkg::stAlpha2};

  always_comb begin
    nextState = state;
    case (state)
      cascadePkg::stIdle:        if (start) nextState = cascadePkg::stPrime;
      cascadePkg::stPrime:       nextState = cascadePkg::stNumStages;
      cascadePkg::stNumStages:   nextState = cascadePkg::stClassCount;
      cascadePkg::stClassCount:  nextState = cascadePkg::stStageThresh;
      cascadePkg::stStageThresh: nextState = cascadePkg::stClassWord;
      cascadePkg::stClassWord:   nextState = cascadePkg::stWeight1;
      cascadePkg::stWeight1:     nextState = cascadePkg::stWeight2;
      cascadePkg::stWeight2: begin
        nextState = threeRects ? cascadePkg::stWeight3 : cascadePkg::stAlpha1;
      end
      cascadePkg::stWeight3:     nextState = cascadePkg::stAlpha1;
      cascadePkg::stAlpha1:      nextState = cascadePkg::stAlpha2;
      cascadePkg::stAlpha2:      nextState = cascadePkg::stRectGo;
      cascadePkg::stRectGo:      nextState = cascadePkg::stRectWait;
      cascadePkg::stRectWait: begin
        if (rectDone) nextState = lastRect ? cascadePkg::stScore : cascadePkg::stRectGo;
      end
      cascadePkg::stScore:       nextState = cascadePkg::stScoreWait;
      cascadePkg::stScoreWait: begin
        if (alphaValid) begin
          nextState = (classLeft == 1) ? cascadePkg::stStageEnd : cascadePkg::stClassWord;
        end
      end
      cascadePkg::stStageEnd:    nextState = cascadePkg::stStageWait;
      cascadePkg::stStageWait: begin
        // first failing stage or the last passing one ends the run
        if (stageResult) begin
          if (!stagePass || stagesLeft == 1) nextState = cascadePkg::stDone;
          else nextState = cascadePkg::stClassCount;
        end
      end
      cascadePkg::stDone:        nextState = cascadePkg::stIdle;
      default:                   nextState = cascadePkg::stIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state       <= cascadePkg::stIdle;
      cascadeAddr <= '0;
      stagesLeft  <= '0;
      classLeft   <= '0;
      rectIdx     <= '0;
      threeRects  <= 1'b0;
      passReg     <= 1'b0;
    end else begin
      state <= nextState;
      if (state == cascadePkg::stIdle) cascadeAddr <= '0;
      else if (addrAdvance) cascadeAddr <= cascadeAddr + 1'b1;
      case (state)
        cascadePkg::stNumStages:  stagesLeft <= $unsigned(cascadeQ.value);
        cascadePkg::stClassCount: classLeft <= $unsigned(cascadeQ.value);
        cascadePkg::stClassWord:  threeRects <= cascadeQ.classifier.threeRects;
        cascadePkg::stAlpha2:     rectIdx <= '0;
        cascadePkg::stRectWait: begin
          if (rectDone && !lastRect) rectIdx <= rectIdx + 1'b1;
        end
        cascadePkg::stScoreWait: begin
          if (alphaValid && classLeft != 1) classLeft <= classLeft - 1'b1;
        end
        cascadePkg::stStageWait: begin
          if (stageResult) begin
            passReg <= stagePass;
            if (stagePass) stagesLeft <= stagesLeft - 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // cascade parameters in layout order
  always_ff @(posedge clk) begin
    case (state)
      cascadePkg::stStageThresh: stageThreshold <= cascadeQ.value;
      cascadePkg::stClassWord: begin
        classThreshold <= cascadePkg::fixedT'(cascadeQ.classifier.threshold);
      end
      cascadePkg::stWeight1:     weight1 <= cascadeQ.value;
      cascadePkg::stWeight2:     weight2 <= cascadeQ.value;
      cascadePkg::stWeight3:     weight3 <= cascadeQ.value;
      cascadePkg::stAlpha1:      alphaLow <= cascadeQ.value;
      cascadePkg::stAlpha2:      alphaHigh <= cascadeQ.value;
      default: ;
    endcase
  end

  always_comb begin
    case (rectIdx)
      2'd0:    weight = weight1;
      2'd1:    weight = weight2;
      default: weight = weight3;
    endcase
  end

  assign ready         = (state == cascadePkg::stIdle);
  assign evalStart     = ready && start;
  assign done          = (state == cascadePkg::stDone);
  assign passFail      = done && passReg;
  assign rectStart     = (state == cascadePkg::stRectGo);
  // area is valid in the rectDone cycle
  assign weightLoad    = (state == cascadePkg::stRectWait) && rectDone;
  assign classifierEnd = (state == cascadePkg::stScore);
  assign stageEnd      = (state == cascadePkg::stStageEnd);

endmodule

/* classifierScore.sv */
`include "featureEval_config.svh"

module classifierScore (
  input  logic              clk,
  input  logic              arstN,
  input  logic              evalStart,
  input  logic              weightLoad,
  input  logic              classifierEnd,
  input  cascadePkg::fixedT weight,
  input  cascadePkg::fixedT classThreshold,
  input  cascadePkg::fixedT alphaLow,
  input  cascadePkg::fixedT alphaHigh,
  input  cascadePkg::fixedT varFactor,
  input  windowPkg::areaT   area,
  output logic              alphaValid,
  output cascadePkg::fixedT alpha
);

  cascadePkg::fixedT                        factor;
  logic signed [`CASCADE_WORD+`INTEGRAL_BITS:0] product;
  logic signed [2*`CASCADE_WORD-1:0]        threshProduct;
  logic signed [`SUM_BITS-1:0]              scaled;
  logic signed [`SUM_BITS-1:0]              normThreshold;
  logic signed [`SUM_BITS-1:0]              sum;

  assign product       = weight * area;
  assign scaled        = `SUM_BITS'(product >>> `FRAC_BITS);
  // threshold scaled by the window's variance normalization
  assign threshProduct = classThreshold * factor;
  assign normThreshold = `SUM_BITS'(threshProduct >>> `FRAC_BITS);

  // factor is taken once per evaluation, together with start
  always_ff @(posedge clk) begin
    if (evalStart) factor <= varFactor;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sum        <= '0;
      alphaValid <= 1'b0;
    end else begin
      alphaValid <= classifierEnd && !evalStart;
      if (evalStart || classifierEnd) sum <= '0;
      else if (weightLoad) sum <= sum + scaled;
    end
  end

  always_ff @(posedge clk) begin
    if (classifierEnd) alpha <= (sum >= normThreshold) ? alphaHigh : alphaLow;
  end

endmodule

/* featureEval_config.svh */
`ifndef FEATURE_EVAL_CONFIG_SVH
`define FEATURE_EVAL_CONFIG_SVH

// one cascade memory word, also the width of weights, alphas and thresholds
`define CASCADE_WORD 16

// fraction bits of the fixed-point weights, thresholds and varFactor
`define FRAC_BITS 8

// one window coordinate, 32x32 window
`define COORD_BITS 5

// integral image value
`define INTEGRAL_BITS 18

// memory address widths
`define FEATURE_ADDR_BITS 8
`define CASCADE_ADDR_BITS 9

// signed classifier and stage accumulators
`define SUM_BITS 32

`endif

/* featureEval_input.txt */
// 0x000 run count, then 4 words per run from 0x010:
// case base, varFactor (8.8), expected passFail, highest feature address allowed
@0000
5
@0010
0800 0100 1 ff
0800 0400 0 ff
1000 0100 1 ff
1800 0100 0 8
0800 0100 1 ff
// case 0x0800: one stage, two classifiers of two rectangles
@0800
1 2 0100 0020 0100 ff00 ff80 0080 0010 0100 ff00 ffc0 0080
@0900
021 022 023 024 041 042 043 044 061 062 063 064 081 082 083 084
@0c21
c8 32 28 0a
@0c41
96 1e 3c 14
@0c61
12c 64 5a 0a
@0c81
b4 3c 32 1e
// case 0x1000: one classifier with three rectangles, weight3 = 2.0
@1000
1 1 0040 8030 0100 ff00 0200 ffc0 0040
@1100
021 022 023 024 041 042 043 044 061 062 063 064
@1421
a0 28 1e 0a
@1441
8c 14 32 14
@1461
46 1e 19 05
// case 0x1800: two stages, the first one fails
@1800
2 1 0050 0064 0100 ff00 ffb0 0050 1 0000 0000 0100 ff00 0010 0010
@1900
021 022 023 024 041 042 043 044 061 062 063 064 081 082 083 084
@1c21
5a 14 0f 05
@1c41
28 0a 19 05
@1c61
40 14 0a 08
@1c81
1e 0a 08 04

/* featureEvaluator.sv */
`include "featureEval_config.svh"

module featureEvaluator (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          start,
  input  cascadePkg::fixedT             varFactor,
  output logic                          ready,
  output logic                          done,
  output logic                          passFail,
  output logic [`CASCADE_ADDR_BITS-1:0] cascadeAddr,
  input  cascadePkg::classifierWordT    cascadeQ,
  output logic [`FEATURE_ADDR_BITS-1:0] featureAddr,
  input  windowPkg::cornerT             featureQ,
  output windowPkg::coordT              windowX,
  output windowPkg::coordT              windowY,
  input  windowPkg::integralT           windowQ
);

  logic              evalStart;
  logic              rectStart;
  logic              rectDone;
  logic              weightLoad;
  logic              classifierEnd;
  logic              alphaValid;
  logic              stageEnd;
  logic              stageResult;
  logic              stagePass;
  cascadePkg::fixedT weight;
  cascadePkg::fixedT classThreshold;
  cascadePkg::fixedT alphaLow;
  cascadePkg::fixedT alphaHigh;
  cascadePkg::fixedT alpha;
  cascadePkg::fixedT stageThreshold;
  windowPkg::areaT   area;

  cascadeSequencer sequencer (
    .clk, .arstN, .start, .cascadeQ, .rectDone, .stagePass, .stageResult, .alphaValid,
    .cascadeAddr, .ready, .done, .passFail, .evalStart, .rectStart, .weightLoad,
    .weight, .classifierEnd, .classThreshold, .alphaLow, .alphaHigh, .stageEnd,
    .stageThreshold
  );

  rectAreaUnit rectArea (
    .clk, .arstN, .evalStart, .rectStart, .featureAddr, .featureQ,
    .windowX, .windowY, .windowQ, .rectDone, .area
  );

  classifierScore score (
    .clk, .arstN, .evalStart, .weightLoad, .classifierEnd, .weight, .classThreshold,
    .alphaLow, .alphaHigh, .varFactor, .area, .alphaValid, .alpha
  );

  stageAccumulator stageAcc (
    .clk, .arstN, .evalStart, .alphaValid, .stageEnd, .alpha, .stageThreshold,
    .stageResult, .stagePass
  );

endmodule

/* featureEvaluatorTb.sv */
`include "featureEval_config.svh"

module featureEvaluatorTb;

  localparam int StimWords = 8192;
  localparam int WaitLimit = 4000;

  logic                          clk;
  logic                          arstN;
  logic                          start;
  cascadePkg::fixedT             varFactor;
  logic                          ready;
  logic                          done;
  logic                          passFail;
  logic [`CASCADE_ADDR_BITS-1:0] cascadeAddr;
  cascadePkg::classifierWordT    cascadeQ;
  logic [`FEATURE_ADDR_BITS-1:0] featureAddr;
  windowPkg::cornerT             featureQ;
  windowPkg::coordT              windowX;
  windowPkg::coordT              windowY;
  windowPkg::integralT           windowQ;

  // run table at 0, one case image per 0x800 words
  logic [31:0] stim [StimWords];
  int          caseBase;
  integer      seed;

  featureEvaluator uut (
    .clk, .arstN, .start, .varFactor, .ready, .done, .passFail, .cascadeAddr, .cascadeQ,
    .featureAddr, .featureQ, .windowX, .windowY, .windowQ
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // three synchronous memories, data one cycle after the address
  always @(posedge clk) begin
    cascadeQ <= stim[caseBase + cascadeAddr][`CASCADE_WORD-1:0];
    featureQ <= stim[caseBase + 'h100 + featureAddr][2*`COORD_BITS-1:0];
    windowQ  <= stim[caseBase + 'h400 + {windowY, windowX}][`INTEGRAL_BITS-1:0];
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "testbench stopped at the first error");
  endtask

  // idle cycles without a start, done must stay low
  task automatic idleCycles(input int count);
    int i;
    for (i = 0; i < count; i++) begin
      @(negedge clk);
      assert (!done) else abortRun($sformatf("Mismatch at %0t: done pulsed without a start", $time));
    end
  endtask

  task automatic waitReady();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!ready) begin
      cycles++;
      if (cycles > WaitLimit) abortRun("The DUT never raised ready, gave up waiting");
      @(negedge clk);
    end
  endtask

  task automatic evaluate(input int runIdx);
    int   runAddr;
    int   cycles;
    int   highestAddr;
    int   addrLimit;
    logic expected;
    runAddr   = 'h10 + 4 * runIdx;
    expected  = stim[runAddr + 2][0];
    addrLimit = stim[runAddr + 3];
    waitReady();
    caseBase = stim[runAddr];
    @(posedge clk);
    start     <= 1'b1;
    varFactor <= stim[runAddr + 1][`CASCADE_WORD-1:0];
    @(posedge clk);
    // varFactor only counts in the start cycle
    start     <= 1'b0;
    varFactor <= '0;
    @(negedge clk);
    assert (!ready) else abortRun($sformatf("Mismatch at %0t: ready high after start", $time));
    cycles      = 0;
    highestAddr = 0;
    while (!done) begin
      if (featureAddr > highestAddr) highestAddr = featureAddr;
      cycles++;
      if (cycles > WaitLimit) begin
        abortRun($sformatf("Run %0d never finished, no done within %0d cycles", runIdx, cycles));
      end
      @(negedge clk);
    end
    assert (passFail == expected) else begin
      abortRun($sformatf("Mismatch at %0t: run %0d passFail %0b, expected %0b",
                         $time, runIdx, passFail, expected));
    end
    // early exit leaves the feature address at the start of the next stage
    assert (highestAddr <= addrLimit) else begin
      abortRun($sformatf("Mismatch at %0t: run %0d read feature address %0d, limit %0d",
                         $time, runIdx, highestAddr, addrLimit));
    end
    @(negedge clk);
    assert (ready && !done) else begin
      abortRun($sformatf("Mismatch at %0t: run %0d ready %0b done %0b after done",
                         $time, runIdx, ready, done));
    end
  endtask

  initial begin
    int i;
    int runCount;
    seed      = 80;
    caseBase  = 0;
    arstN     <= 1'b0;
    start     <= 1'b0;
    varFactor <= '0;
    for (i = 0; i < StimWords; i++) begin
      stim[i] = (i * 32'h0001_9e37) ^ 32'h00a5_5a00;
    end
    $readmemh("featureEval_input.txt", stim);
    runCount = stim[0];
    assert (runCount > 0 && runCount < 64) else abortRun("The stimulus file holds no run table");
    repeat (16) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    assert (ready && !done && !passFail) else begin
      abortRun($sformatf("Mismatch at %0t: ready %0b done %0b passFail %0b after reset",
                         $time, ready, done, passFail));
    end
    idleCycles(8);
    for (i = 0; i < runCount; i++) begin
      evaluate(i);
      idleCycles($unsigned($random(seed)) % 4);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

/* list.f */
+incdir+.
cascadePkg.sv
windowPkg.sv
cascadeSequencer.sv
rectAreaUnit.sv
classifierScore.sv
stageAccumulator.sv
featureEvaluator.sv
featureEvaluatorTb.sv

/* rectAreaUnit.sv */
`include "featureEval_config.svh"

module rectAreaUnit (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          evalStart,
  input  logic                          rectStart,
  output logic [`FEATURE_ADDR_BITS-1:0] featureAddr,
  input  windowPkg::cornerT             featureQ,
  output windowPkg::coordT              windowX,
  output windowPkg::coordT              windowY,
  input  windowPkg::integralT           windowQ,
  output logic                          rectDone,
  output windowPkg::areaT               area
);

  // phase 1 is the cycle after rectStart, window data arrives in phases 2 to 5
  logic [2:0]      phase;
  windowPkg::areaT acc;
  windowPkg::areaT cornerVal;

  // returned corner goes straight to the window port
  assign windowX   = featureQ[`COORD_BITS-1:0];
  assign windowY   = featureQ[2*`COORD_BITS-1:`COORD_BITS];
  assign cornerVal = windowPkg::areaT'({1'b0, windowQ});

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      phase       <= '0;
      featureAddr <= '0;
      rectDone    <= 1'b0;
    end else begin
      rectDone <= (phase == 3'd5);
      if (rectStart) phase <= 3'd1;
      else if (phase == 3'd5) phase <= '0;
      else if (phase != '0) phase <= phase + 1'b1;
      // one corner address per cycle, from rectStart up to phase 3
      if (evalStart) featureAddr <= '0;
      else if (rectStart || (phase != '0 && phase < 3'd4)) featureAddr <= featureAddr + 1'b1;
    end
  end

  // first minus second minus third plus fourth
  always_ff @(posedge clk) begin
    case (phase)
      3'd2:       acc <= cornerVal;
      3'd3, 3'd4: acc <= acc - cornerVal;
      3'd5:       area <= acc + cornerVal;
      default: ;
    endcase
  end

endmodule

/* stageAccumulator.sv */
`include "featureEval_config.svh"

module stageAccumulator (
  input  logic              clk,
  input  logic              arstN,
  input  logic              evalStart,
  input  logic              alphaValid,
  input  logic              stageEnd,
  input  cascadePkg::fixedT alpha,
  input  cascadePkg::fixedT stageThreshold,
  output logic              stageResult,
  output logic              stagePass
);

  logic signed [`SUM_BITS-1:0] stageSum;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      stageSum    <= '0;
      stageResult <= 1'b0;
      stagePass   <= 1'b0;
    end else begin
      stageResult <= stageEnd && !evalStart;
      if (evalStart) begin
        stageSum  <= '0;
        stagePass <= 1'b0;
      end else if (stageEnd) begin
        // compare, then start the next stage from zero
        stagePass <= (stageSum >= `SUM_BITS'(stageThreshold));
        stageSum  <= '0;
      end else if (alphaValid) begin
        stageSum <= stageSum + `SUM_BITS'(alpha);
      end
    end
  end

endmodule

/* windowPkg.sv */
`include "featureEval_config.svh"

package windowPkg;

  // one coordinate inside the detection window
  typedef logic [`COORD_BITS-1:0] coordT;

  // feature memory word, y in the upper half and x in the lower half
  typedef logic [2*`COORD_BITS-1:0] cornerT;

  // unsigned integral image value
  typedef logic [`INTEGRAL_BITS-1:0] integralT;

  // rectangle area, one extra bit for the signed corner sums
  typedef logic signed [`INTEGRAL_BITS:0] areaT;

endpackage
